// File: project.f
+incdir+dv
hdl/cap_rf_pkg.sv
hdl/cap_rf_decode.sv
hdl/cap_rf_array.sv
hdl/cap_rf_guard.sv
hdl/cap_rf_read.sv
hdl/cap_rf_top.sv
dv/cap_rf_tb.sv

// File: Bender.yml
package:
  name: cap_rf

sources:
  - files:
      - hdl/cap_rf_pkg.sv
      - hdl/cap_rf_decode.sv
      - hdl/cap_rf_array.sv
      - hdl/cap_rf_guard.sv
      - hdl/cap_rf_read.sv
      - hdl/cap_rf_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cap_rf_tb.sv

// File: dv/cap_rf_model.svh
// ##############################
// register file reference model
// expected data, capabilities and ready bits
// ##############################

  logic [31:0]          exp_data [32];
  cap_rf_pkg::reg_cap_t exp_cap  [32];
  logic [31:0]          exp_rdy;

  task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
      exp_data[i] = '0;
      exp_cap[i]  = cap_rf_pkg::NULL_REG_CAP;
    end
    exp_rdy = '1;
  endtask

  // one rising edge, register 0 never changes
  task automatic model_update(input cap_rf_pkg::wr_req_t   wr,
                              input cap_rf_pkg::trvk_req_t rvk,
                              input cap_rf_pkg::trsv_req_t rsv);
    cap_rf_pkg::reg_cap_t c;
    if (wr.we && wr.addr != 0) begin
      exp_data[wr.addr] = wr.data;
      exp_cap[wr.addr]  = wr.cap;
    end
    // tag clear lands on top of a same-cycle write
    if (rvk.en && rvk.addr != 0) begin
      if (rvk.clrtag) begin
        c                 = exp_cap[rvk.addr];
        c.valid           = 1'b0;
        exp_cap[rvk.addr] = c;
      end
      exp_rdy[rvk.addr] = 1'b1;
    end
    // reserve has the last word on the ready bit
    if (rsv.en && rsv.addr != 0) begin
      exp_rdy[rsv.addr] = 1'b0;
    end
  endtask

  function automatic logic [31:0] expect_data(input logic [4:0] addr);
    return exp_data[addr];
  endfunction

  function automatic cap_rf_pkg::reg_cap_t expect_cap(input logic [4:0]            addr,
                                                      input cap_rf_pkg::trvk_req_t rvk);
    cap_rf_pkg::reg_cap_t c;
    c = exp_cap[addr];
    if (rvk.en && rvk.clrtag && rvk.addr == addr) begin
      c.valid = 1'b0;
    end
    return c;
  endfunction

  // pending revoke already counts as released
  function automatic logic [31:0] expect_rdy(input cap_rf_pkg::trvk_req_t rvk);
    logic [31:0] r;
    r = exp_rdy;
    if (rvk.en && rvk.addr != 0) begin
      r[rvk.addr] = 1'b1;
    end
    return r;
  endfunction

// File: dv/cap_rf_tb.sv
// ##############################
// capability register file testbench
// directed and random checks against a model
// ##############################

`timescale 1ns/10ps

module cap_rf_tb;

  localparam int unsigned CLK_HALF   = 10;
  // mid low phase, inputs settled and no edge near
  localparam int unsigned SAMPLE_DLY = 5;

  localparam cap_rf_pkg::wr_req_t   WR_IDLE  = '0;
  localparam cap_rf_pkg::trvk_req_t RVK_IDLE = '0;
  localparam cap_rf_pkg::trsv_req_t RSV_IDLE = '0;

  logic                  clk;
  logic                  rst_n;
  cap_rf_pkg::wr_req_t   wr_req;
  cap_rf_pkg::trvk_req_t trvk_req;
  cap_rf_pkg::trsv_req_t trsv_req;
  logic [4:0]            raddr_a;
  logic [4:0]            raddr_b;
  logic [31:0]           rdata_a;
  cap_rf_pkg::reg_cap_t  rcap_a;
  logic [31:0]           rdata_b;
  cap_rf_pkg::reg_cap_t  rcap_b;
  logic [31:0]           reg_rdy;
  logic                  alert;

  logic        check_en;
  string       cur_test;
  int unsigned err_cnt;
  int unsigned timeout_cnt;
  int unsigned test_cnt;
  int unsigned bad_test_cnt;
  int unsigned start_fails;

  `include "cap_rf_model.svh"

  cap_rf_top i_dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .wr_req_i   (wr_req),
    .trvk_req_i (trvk_req),
    .trsv_req_i (trsv_req),
    .raddr_a_i  (raddr_a),
    .raddr_b_i  (raddr_b),
    .rdata_a_o  (rdata_a),
    .rcap_a_o   (rcap_a),
    .rdata_b_o  (rdata_b),
    .rcap_b_o   (rcap_b),
    .reg_rdy_o  (reg_rdy),
    .alert_o    (alert)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // model follows the register state at every rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      model_update(wr_req, trvk_req, trsv_req);
    end
  end

  task automatic check_val(input string what, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Error: %s %s expected %08h actual %08h", cur_test, what, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic compare_outputs();
    check_val("rdata_a", expect_data(raddr_a), rdata_a);
    check_val("rcap_a", expect_cap(raddr_a, trvk_req), rcap_a);
    check_val("rdata_b", expect_data(raddr_b), rdata_b);
    check_val("rcap_b", expect_cap(raddr_b, trvk_req), rcap_b);
    check_val("reg_rdy", expect_rdy(trvk_req), reg_rdy);
    check_val("alert", 32'd0, {31'd0, alert});
  endtask

  // last cycle is checked before the new stimulus lands
  always @(negedge clk) begin
    if (check_en) begin
      compare_outputs();
    end
  end

  function automatic cap_rf_pkg::wr_req_t wr_of(input logic we, input logic [4:0] addr,
                                                input logic [31:0] data,
                                                input cap_rf_pkg::reg_cap_t cap);
    cap_rf_pkg::wr_req_t r;
    r.we   = we;
    r.addr = addr;
    r.data = data;
    r.cap  = cap;
    return r;
  endfunction

  function automatic cap_rf_pkg::trvk_req_t rvk_of(input logic en, input logic clrtag,
                                                   input logic [4:0] addr);
    cap_rf_pkg::trvk_req_t r;
    r.en     = en;
    r.clrtag = clrtag;
    r.addr   = addr;
    return r;
  endfunction

  function automatic cap_rf_pkg::trsv_req_t rsv_of(input logic en, input logic [4:0] addr);
    cap_rf_pkg::trsv_req_t r;
    r.en   = en;
    r.addr = addr;
    return r;
  endfunction

  // random fields, tag set so a revoke has something to clear
  function automatic cap_rf_pkg::reg_cap_t rand_cap();
    cap_rf_pkg::reg_cap_t c;
    c       = $urandom();
    c.valid = 1'b1;
    return c;
  endfunction

  task automatic step(input cap_rf_pkg::wr_req_t wr, input cap_rf_pkg::trvk_req_t rvk,
                      input cap_rf_pkg::trsv_req_t rsv, input logic [4:0] ra,
                      input logic [4:0] rb);
    @(negedge clk);
    wr_req   <= wr;
    trvk_req <= rvk;
    trsv_req <= rsv;
    raddr_a  <= ra;
    raddr_b  <= rb;
  endtask

  // view before the rising edge commits the request
  task automatic check_same_cycle();
    #SAMPLE_DLY;
    compare_outputs();
  endtask

  task automatic wait_all_ready(input int unsigned limit);
    int unsigned n;
    n = 0;
    while (reg_rdy !== '1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (reg_rdy !== '1) begin
      $display("%s: reg_rdy_o did not return to all ones within %0d cycles", cur_test, limit);
      timeout_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    start_fails = err_cnt + timeout_cnt;
  endtask

  task automatic end_test();
    int unsigned fails;
    step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'd0, 5'd0);
    // comparison of the falling edge above is done by now
    @(posedge clk);
    fails = err_cnt + timeout_cnt - start_fails;
    test_cnt++;
    if (fails == 0) begin
      $display("test %s: PASS", cur_test);
    end else begin
      bad_test_cnt++;
      $display("test %s: FAIL with %0d errors", cur_test, fails);
    end
  endtask

  task automatic test_reset_state();
    begin_test("reset_state");
    wait_all_ready(4);
    for (int i = 0; i < 32; i++) begin
      step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'(i), 5'(31 - i));
    end
    end_test();
  endtask

  task automatic test_write_read();
    logic [4:0] addr;
    begin_test("write_read");
    for (int i = 0; i < 40; i++) begin
      addr = 5'($urandom_range(0, 31));
      step(wr_of(1'b1, addr, $urandom(), rand_cap()), RVK_IDLE, RSV_IDLE, addr,
           5'($urandom_range(0, 31)));
    end
    // register 0 stays zero and null
    step(wr_of(1'b1, 5'd0, 32'hffff_ffff, rand_cap()), RVK_IDLE, RSV_IDLE, 5'd0, 5'd0);
    for (int i = 0; i < 40; i++) begin
      step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)));
    end
    end_test();
  endtask

  task automatic test_revoke();
    begin_test("revoke");
    step(wr_of(1'b1, 5'd5, 32'h0000_0505, rand_cap()), RVK_IDLE, RSV_IDLE, 5'd0, 5'd0);
    step(WR_IDLE, rvk_of(1'b1, 1'b1, 5'd5), RSV_IDLE, 5'd5, 5'd5);
    check_same_cycle();
    check_val("valid_bypass", 32'd0, {31'd0, rcap_a.valid});
    step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'd5, 5'd4);
    // write plus revoke keeps the new fields, tag low
    step(wr_of(1'b1, 5'd9, 32'h0000_0909, rand_cap()), rvk_of(1'b1, 1'b1, 5'd9), RSV_IDLE,
         5'd9, 5'd5);
    step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'd9, 5'd9);
    end_test();
  endtask

  task automatic test_ready();
    begin_test("ready");
    step(WR_IDLE, RVK_IDLE, rsv_of(1'b1, 5'd12), 5'd12, 5'd0);
    step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'd12, 5'd0);
    check_val("rdy_reserved", 32'd0, {31'd0, reg_rdy[12]});
    step(WR_IDLE, rvk_of(1'b1, 1'b0, 5'd12), RSV_IDLE, 5'd12, 5'd0);
    check_same_cycle();
    check_val("rdy_bypass", 32'd1, {31'd0, reg_rdy[12]});
    step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'd12, 5'd0);
    // reserve beats a release in the same cycle
    step(WR_IDLE, rvk_of(1'b1, 1'b0, 5'd13), rsv_of(1'b1, 5'd13), 5'd13, 5'd0);
    step(WR_IDLE, RVK_IDLE, RSV_IDLE, 5'd13, 5'd0);
    step(WR_IDLE, rvk_of(1'b1, 1'b0, 5'd13), RSV_IDLE, 5'd13, 5'd0);
    wait_all_ready(4);
    end_test();
  endtask

  task automatic test_random_mix();
    cap_rf_pkg::wr_req_t   wr;
    cap_rf_pkg::trvk_req_t rvk;
    cap_rf_pkg::trsv_req_t rsv;
    begin_test("random_mix");
    for (int n = 0; n < 300; n++) begin
      wr  = wr_of(1'($urandom_range(0, 1)), 5'($urandom_range(0, 31)), $urandom(), rand_cap());
      rvk = rvk_of($urandom_range(0, 3) == 0, 1'($urandom_range(0, 1)),
                   5'($urandom_range(0, 31)));
      rsv = rsv_of($urandom_range(0, 3) == 0, 5'($urandom_range(0, 31)));
      step(wr, rvk, rsv, 5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)));
    end
    end_test();
  endtask

  initial begin
    void'($urandom(11));
    rst_n        = 1'b0;
    check_en     = 1'b0;
    wr_req       = WR_IDLE;
    trvk_req     = RVK_IDLE;
    trsv_req     = RSV_IDLE;
    raddr_a      = '0;
    raddr_b      = '0;
    cur_test     = "reset";
    err_cnt      = 0;
    timeout_cnt  = 0;
    test_cnt     = 0;
    bad_test_cnt = 0;
    start_fails  = 0;
    model_reset();
    repeat (5) @(negedge clk);
    rst_n    <= 1'b1;
    check_en <= 1'b1;
    test_reset_state();
    test_write_read();
    test_revoke();
    test_ready();
    test_random_mix();
    $display("tests %0d, bad tests %0d, check errors %0d, timeouts %0d",
             test_cnt, bad_test_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: hdl/cap_rf_top.sv
// ##############################
// capability register file top
// decoder, array, guard and read side
// ##############################

`timescale 1ns/10ps

module cap_rf_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // requests
  input  cap_rf_pkg::wr_req_t               wr_req_i,
  input  cap_rf_pkg::trvk_req_t             trvk_req_i,
  input  cap_rf_pkg::trsv_req_t             trsv_req_i,

  // read ports
  input  logic [cap_rf_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [cap_rf_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [cap_rf_pkg::DATA_W-1:0]     rdata_a_o,
  output cap_rf_pkg::reg_cap_t              rcap_a_o,
  output logic [cap_rf_pkg::DATA_W-1:0]     rdata_b_o,
  output cap_rf_pkg::reg_cap_t              rcap_b_o,

  output logic [cap_rf_pkg::NUM_REGS-1:0]   reg_rdy_o,
  output logic                              alert_o
);

  cap_rf_pkg::rf_dec_t             dec;
  cap_rf_pkg::rf_data_t            rf_data;
  cap_rf_pkg::rf_caps_t            rf_caps;
  logic [cap_rf_pkg::NUM_REGS-1:0] rdy_vec;

  cap_rf_decode i_decode (
    .wr_req_i   (wr_req_i),
    .trvk_req_i (trvk_req_i),
    .trsv_req_i (trsv_req_i),
    .dec_o      (dec)
  );

  cap_rf_array i_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .dec_i     (dec),
    .wdata_i   (wr_req_i.data),
    .wcap_i    (wr_req_i.cap),
    .rf_data_o (rf_data),
    .rf_caps_o (rf_caps),
    .rdy_vec_o (rdy_vec)
  );

  cap_rf_guard i_guard (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .dec_i     (dec),
    .rdy_vec_i (rdy_vec),
    .rf_caps_i (rf_caps),
    .alert_o   (alert_o)
  );

  cap_rf_read i_read (
    .raddr_a_i (raddr_a_i),
    .raddr_b_i (raddr_b_i),
    .rf_data_i (rf_data),
    .rf_caps_i (rf_caps),
    .rdy_vec_i (rdy_vec),
    .dec_i     (dec),
    .rdata_a_o (rdata_a_o),
    .rcap_a_o  (rcap_a_o),
    .rdata_b_o (rdata_b_o),
    .rcap_b_o  (rcap_b_o),
    .reg_rdy_o (reg_rdy_o)
  );

endmodule

// File: hdl/cap_rf_read.sv
// ##############################
// read ports
// muxes plus same-cycle revoke bypass
// ##############################

`timescale 1ns/10ps

module cap_rf_read (
  input  logic [cap_rf_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [cap_rf_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  cap_rf_pkg::rf_data_t              rf_data_i,
  input  cap_rf_pkg::rf_caps_t              rf_caps_i,
  input  logic [cap_rf_pkg::NUM_REGS-1:0]   rdy_vec_i,
  input  cap_rf_pkg::rf_dec_t               dec_i,
  output logic [cap_rf_pkg::DATA_W-1:0]     rdata_a_o,
  output cap_rf_pkg::reg_cap_t              rcap_a_o,
  output logic [cap_rf_pkg::DATA_W-1:0]     rdata_b_o,
  output cap_rf_pkg::reg_cap_t              rcap_b_o,
  output logic [cap_rf_pkg::NUM_REGS-1:0]   reg_rdy_o
);

  // stored capability, tag dropped if revoked this cycle
  function automatic cap_rf_pkg::reg_cap_t read_cap(
    input logic [cap_rf_pkg::REG_ADDR_W-1:0] addr,
    input cap_rf_pkg::rf_caps_t              caps,
    input logic [cap_rf_pkg::NUM_REGS-1:0]   clr_vec
  );
    cap_rf_pkg::reg_cap_t cap;
    cap = caps[addr];
    if (clr_vec[addr]) begin
      cap.valid = 1'b0;
    end
    return cap;
  endfunction

  // data has no forwarding, a write shows up next cycle
  assign rdata_a_o = rf_data_i[raddr_a_i];
  assign rdata_b_o = rf_data_i[raddr_b_i];

  assign rcap_a_o = read_cap(raddr_a_i, rf_caps_i, dec_i.clr_vec);
  assign rcap_b_o = read_cap(raddr_b_i, rf_caps_i, dec_i.clr_vec);

  // a revoke releases the register already in this cycle
  assign reg_rdy_o = rdy_vec_i | dec_i.rel_vec;

endmodule

// File: hdl/cap_rf_guard.sv
// ##############################
// fault guard
// shadow ready vector and revoke readback
// ##############################

`timescale 1ns/10ps

module cap_rf_guard (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  cap_rf_pkg::rf_dec_t             dec_i,
  input  logic [cap_rf_pkg::NUM_REGS-1:0] rdy_vec_i,
  input  cap_rf_pkg::rf_caps_t            rf_caps_i,
  output logic                            alert_o
);

  // enables from the previous cycle
  logic [cap_rf_pkg::NUM_REGS-1:0] clr_q;
  logic [cap_rf_pkg::NUM_REGS-1:0] rsv_q;
  logic [cap_rf_pkg::NUM_REGS-1:0] rel_q;

  // ready vector one cycle late and its independent shadow
  logic [cap_rf_pkg::NUM_REGS-1:0] rdy_q;
  logic [cap_rf_pkg::NUM_REGS-1:0] rdy_shdw_q;

  logic shdw_mismatch;
  logic cap_rvk_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_q <= '0;
      rsv_q <= '0;
      rel_q <= '0;
      rdy_q <= '1;
    end else begin
      clr_q <= dec_i.clr_vec;
      rsv_q <= dec_i.rsv_vec;
      rel_q <= dec_i.rel_vec;
      rdy_q <= rdy_vec_i;
    end
  end

  // replays the array's ready update one cycle behind
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdy_shdw_q <= '1;
    end else begin
      for (int i = 0; i < cap_rf_pkg::NUM_REGS; i++) begin
        if (rsv_q[i]) begin
          rdy_shdw_q[i] <= 1'b0;
        end else if (rel_q[i]) begin
          rdy_shdw_q[i] <= 1'b1;
        end
      end
    end
  end

  assign shdw_mismatch = (rdy_shdw_q != rdy_q);

  // a revoked register must now hold its tag low
  always_comb begin
    cap_rvk_err = 1'b0;
    for (int i = 0; i < cap_rf_pkg::NUM_REGS; i++) begin
      cap_rvk_err = cap_rvk_err | (clr_q[i] & rf_caps_i[i].valid);
    end
  end

  assign alert_o = shdw_mismatch | cap_rvk_err;

endmodule

// File: hdl/cap_rf_array.sv
// ##############################
// register array
// data, capability and ready flops
// ##############################

`timescale 1ns/10ps

module cap_rf_array (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  cap_rf_pkg::rf_dec_t                 dec_i,
  input  logic [cap_rf_pkg::DATA_W-1:0]       wdata_i,
  input  cap_rf_pkg::reg_cap_t                wcap_i,
  output cap_rf_pkg::rf_data_t                rf_data_o,
  output cap_rf_pkg::rf_caps_t                rf_caps_o,
  output logic [cap_rf_pkg::NUM_REGS-1:0]     rdy_vec_o
);

  // no storage for register 0
  logic [cap_rf_pkg::DATA_W-1:0] data_q [1:cap_rf_pkg::NUM_REGS-1];
  cap_rf_pkg::reg_cap_t          cap_q  [1:cap_rf_pkg::NUM_REGS-1];
  logic                          rdy_q  [1:cap_rf_pkg::NUM_REGS-1];

  // written capability with its tag already stripped
  cap_rf_pkg::reg_cap_t wcap_clr;

  always_comb begin
    wcap_clr       = wcap_i;
    wcap_clr.valid = 1'b0;
  end

  // data words
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < cap_rf_pkg::NUM_REGS; i++) begin
        data_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < cap_rf_pkg::NUM_REGS; i++) begin
        if (dec_i.we_vec[i]) begin
          data_q[i] <= wdata_i;
        end
      end
    end
  end

  // capability words, revocation wins over the written tag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < cap_rf_pkg::NUM_REGS; i++) begin
        cap_q[i] <= cap_rf_pkg::NULL_REG_CAP;
      end
    end else begin
      for (int i = 1; i < cap_rf_pkg::NUM_REGS; i++) begin
        if (dec_i.clr_vec[i] && dec_i.we_vec[i]) begin
          cap_q[i] <= wcap_clr;
        end else if (dec_i.clr_vec[i]) begin
          // keep bounds and perms, drop only the tag
          cap_q[i].valid <= 1'b0;
        end else if (dec_i.we_vec[i]) begin
          cap_q[i] <= wcap_i;
        end
      end
    end
  end

  // ready bits, reserve beats release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < cap_rf_pkg::NUM_REGS; i++) begin
        rdy_q[i] <= 1'b1;
      end
    end else begin
      for (int i = 1; i < cap_rf_pkg::NUM_REGS; i++) begin
        if (dec_i.rsv_vec[i]) begin
          rdy_q[i] <= 1'b0;
        end else if (dec_i.rel_vec[i]) begin
          rdy_q[i] <= 1'b1;
        end
      end
    end
  end

  // pack into banks, entry 0 is zero, null and always ready
  always_comb begin
    rf_data_o[0] = '0;
    rf_caps_o[0] = cap_rf_pkg::NULL_REG_CAP;
    rdy_vec_o[0] = 1'b1;
    for (int i = 1; i < cap_rf_pkg::NUM_REGS; i++) begin
      rf_data_o[i] = data_q[i];
      rf_caps_o[i] = cap_q[i];
      rdy_vec_o[i] = rdy_q[i];
    end
  end

endmodule

// File: hdl/cap_rf_decode.sv
// ##############################
// request decoder
// one-hot enables for write, revoke and reserve
// ##############################

`timescale 1ns/10ps

module cap_rf_decode (
  input  cap_rf_pkg::wr_req_t   wr_req_i,
  input  cap_rf_pkg::trvk_req_t trvk_req_i,
  input  cap_rf_pkg::trsv_req_t trsv_req_i,
  output cap_rf_pkg::rf_dec_t   dec_o
);

  // one-hot select qualified by the enable
  // register 0 is hard-wired, so its bit never fires
  function automatic logic [cap_rf_pkg::NUM_REGS-1:0] addr_onehot(
    input logic [cap_rf_pkg::REG_ADDR_W-1:0] addr,
    input logic                              en
  );
    logic [cap_rf_pkg::NUM_REGS-1:0] vec;
    vec       = '0;
    vec[addr] = en;
    vec[0]    = 1'b0;
    return vec;
  endfunction

  logic trvk_clr;

  // only a clearing revoke touches the stored tag
  assign trvk_clr = trvk_req_i.en & trvk_req_i.clrtag;

  always_comb begin
    // RF_OP_WRITE
    dec_o.we_vec  = addr_onehot(wr_req_i.addr, wr_req_i.we);

    // RF_OP_REVOKE with clrtag
    dec_o.clr_vec = addr_onehot(trvk_req_i.addr, trvk_clr);

    // RF_OP_RESERVE
    dec_o.rsv_vec = addr_onehot(trsv_req_i.addr, trsv_req_i.en);

    // any RF_OP_REVOKE releases the ready bit, clrtag or not
    dec_o.rel_vec = addr_onehot(trvk_req_i.addr, trvk_req_i.en);
  end

endmodule

// File: hdl/cap_rf_pkg.sv
// ##############################
// capability register file package
// shared types and constants
// ##############################

package cap_rf_pkg;

  // register bank geometry
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned DATA_W     = 32;

  // capability metadata word, tag bit on top
  typedef struct packed {
    logic       valid;
    logic [5:0] perms;
    logic [2:0] otype;
    logic [3:0] cexp;
    logic [8:0] top;
    logic [8:0] base;
  } reg_cap_t;

  localparam reg_cap_t NULL_REG_CAP = '0;

  // write port, data and capability go together
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
    reg_cap_t              cap;
  } wr_req_t;

  // tag revocation strobe
  typedef struct packed {
    logic                  en;
    logic                  clrtag;
    logic [REG_ADDR_W-1:0] addr;
  } trvk_req_t;

  // tag reservation strobe
  typedef struct packed {
    logic                  en;
    logic [REG_ADDR_W-1:0] addr;
  } trsv_req_t;

  // per-register enables, bit 0 never set
  typedef struct packed {
    logic [NUM_REGS-1:0] we_vec;
    logic [NUM_REGS-1:0] clr_vec;
    logic [NUM_REGS-1:0] rsv_vec;
    logic [NUM_REGS-1:0] rel_vec;
  } rf_dec_t;

  typedef logic [NUM_REGS-1:0][DATA_W-1:0] rf_data_t;
  typedef reg_cap_t [NUM_REGS-1:0] rf_caps_t;

  // request kinds
  typedef enum logic [1:0] {
    RF_OP_NONE,
    RF_OP_WRITE,
    RF_OP_REVOKE,
    RF_OP_RESERVE
  } rf_op_e;

endpackage
